// File: source/uart_axi_pkg.sv
package uart_axi_pkg;

	// bus geometry
	parameter int AXI_ADDR_W = 32;
	parameter int AXI_DATA_W = 32;

	// register window, offsets 0x0..0xC
	parameter logic [AXI_ADDR_W-1:0] UART_BASE_ADDR = 32'h2000_0000;
	parameter logic [AXI_ADDR_W-1:0] UART_MASK_ADDR = 32'h0000_000f;

	parameter int UART_BYTE_W = 8;
	parameter int FIFO_DEPTH  = 32; // power of two

	// register select, taken from address bits 3:2
	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0,
		REG_STATUS = 2'd1,
		REG_RDATA  = 2'd2,
		REG_WDATA  = 2'd3
	} reg_sel_t;

	// ctrl word as named fields
	typedef struct packed {
		logic [15:0] baud_div; // bits 31:16
		logic [13:0] rsvd;
		logic        rx_en;    // bit 1
		logic        tx_en;    // bit 0
	} uart_ctrl_fields_t;

	// ctrl word, seen as bytes for strobed writes or as fields for decode
	typedef union packed {
		logic [3:0][UART_BYTE_W-1:0] bytes;
		uart_ctrl_fields_t           fields;
	} uart_ctrl_u;

endpackage

// File: source/axi_req_decode.sv
module axi_req_decode (
	input  logic                                  s_axi_aclk_i,
	input  logic                                  s_axi_aresetn_i,
	input  logic [uart_axi_pkg::AXI_ADDR_W-1:0]   s_axi_araddr_i,
	input  logic                                  s_axi_arvalid_i,
	input  logic [uart_axi_pkg::AXI_ADDR_W-1:0]   s_axi_awaddr_i,
	input  logic                                  s_axi_awvalid_i,
	input  logic [uart_axi_pkg::AXI_DATA_W-1:0]   s_axi_wdata_i,
	input  logic [uart_axi_pkg::AXI_DATA_W/8-1:0] s_axi_wstrb_i,
	input  logic                                  s_axi_wvalid_i,
	input  logic                                  rd_busy_i,
	input  logic                                  wr_busy_i,
	output logic                                  s_axi_arready_o,
	output logic                                  s_axi_awready_o,
	output logic                                  s_axi_wready_o,
	output logic                                  rd_req_o,
	output uart_axi_pkg::reg_sel_t                rd_sel_o,
	output logic                                  rd_hit_o,
	output logic                                  wr_req_o,
	output uart_axi_pkg::reg_sel_t                wr_sel_o,
	output logic                                  wr_hit_o,
	output logic [uart_axi_pkg::AXI_DATA_W-1:0]   wr_data_o,
	output logic [uart_axi_pkg::AXI_DATA_W/8-1:0] wr_strb_o
);
	import uart_axi_pkg::*;

	logic ar_fire;
	logic aw_fire;

	function automatic logic in_window(input logic [AXI_ADDR_W-1:0] addr);
		return (addr & ~UART_MASK_ADDR) == UART_BASE_ADDR;
	endfunction

	// one request of each kind in flight at most
	assign s_axi_arready_o = ~(rd_req_o | rd_busy_i);
	assign s_axi_awready_o = ~(wr_req_o | wr_busy_i);
	assign s_axi_wready_o  = s_axi_awready_o; // aw and w taken together

	assign ar_fire = s_axi_arvalid_i & s_axi_arready_o;
	assign aw_fire = s_axi_awvalid_i & s_axi_wvalid_i & s_axi_awready_o & s_axi_wready_o;

	always_ff @(posedge s_axi_aclk_i) begin
		if (!s_axi_aresetn_i) begin
			rd_req_o <= 1'b0;
			wr_req_o <= 1'b0;
		end else begin
			rd_req_o <= ar_fire; // single cycle pulse
			wr_req_o <= aw_fire;
		end
	end

	// decoded request, qualified by the pulses above
	always_ff @(posedge s_axi_aclk_i) begin
		if (ar_fire) begin
			rd_sel_o <= reg_sel_t'(s_axi_araddr_i[3:2]);
			rd_hit_o <= in_window(s_axi_araddr_i);
		end
		if (aw_fire) begin
			wr_sel_o  <= reg_sel_t'(s_axi_awaddr_i[3:2]);
			wr_hit_o  <= in_window(s_axi_awaddr_i);
			wr_data_o <= s_axi_wdata_i;
			wr_strb_o <= s_axi_wstrb_i;
		end
	end

endmodule

// File: source/uart_byte_fifo.sv
module uart_byte_fifo #(
	parameter int FIFO_DEPTH = uart_axi_pkg::FIFO_DEPTH
) (
	input  logic                               s_axi_aclk_i,
	input  logic                               s_axi_aresetn_i,
	input  logic                               push_i,
	input  logic [uart_axi_pkg::UART_BYTE_W-1:0] push_data_i,
	input  logic                               pop_i,
	output logic [uart_axi_pkg::UART_BYTE_W-1:0] head_o,
	output logic                               full_o,
	output logic                               empty_o
);
	import uart_axi_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(FIFO_DEPTH);

	logic [UART_BYTE_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]       wr_ptr_q;
	logic [PTR_W-1:0]       rd_ptr_q;
	logic [CNT_W-1:0]       count_q;
	logic                   do_push;
	logic                   do_pop;

	assign full_o  = (count_q == DEPTH_CNT);
	assign empty_o = (count_q == '0);

	// overflow and underflow are dropped here
	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & ~empty_o;

	assign head_o = mem[rd_ptr_q]; // first-word fall-through

	always_ff @(posedge s_axi_aclk_i) begin
		if (do_push) begin
			mem[wr_ptr_q] <= push_data_i;
		end
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (!s_axi_aresetn_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

endmodule

// File: source/uart_reg_stage.sv
module uart_reg_stage #(
	parameter int FIFO_DEPTH = uart_axi_pkg::FIFO_DEPTH
) (
	input  logic                                  s_axi_aclk_i,
	input  logic                                  s_axi_aresetn_i,
	input  logic                                  rd_req_i,
	input  uart_axi_pkg::reg_sel_t                rd_sel_i,
	input  logic                                  rd_hit_i,
	input  logic                                  wr_req_i,
	input  uart_axi_pkg::reg_sel_t                wr_sel_i,
	input  logic                                  wr_hit_i,
	input  logic [uart_axi_pkg::AXI_DATA_W-1:0]   wr_data_i,
	input  logic [uart_axi_pkg::AXI_DATA_W/8-1:0] wr_strb_i,
	input  logic [uart_axi_pkg::UART_BYTE_W-1:0]  rx_i,
	input  logic                                  r_done_i,
	input  logic                                  t_done_i,
	output logic                                  rd_done_o,
	output logic [uart_axi_pkg::AXI_DATA_W-1:0]   rd_data_o,
	output logic                                  wr_done_o,
	output logic [uart_axi_pkg::UART_BYTE_W-1:0]  tx_o,
	output logic                                  tx_en_o,
	output logic                                  rx_en_o,
	output logic [15:0]                           baud_div_o
);
	import uart_axi_pkg::*;

	uart_ctrl_u             ctrl_q;
	logic                   ctrl_wr;
	logic                   tx_push;
	logic                   tx_pop;
	logic                   tx_full;
	logic                   tx_empty;
	logic                   rx_push;
	logic                   rx_pop;
	logic                   rx_full;
	logic                   rx_empty;
	logic [UART_BYTE_W-1:0] rx_head;
	logic [3:0]             status;

	assign ctrl_wr = wr_req_i & wr_hit_i & (wr_sel_i == REG_CTRL);
	assign tx_push = wr_req_i & wr_hit_i & (wr_sel_i == REG_WDATA) & wr_strb_i[0];
	assign rx_pop  = rd_req_i & rd_hit_i & (rd_sel_i == REG_RDATA);

	// enables drop while there is nothing to send or no room to receive
	assign tx_en_o = ctrl_q.fields.tx_en & ~tx_empty;
	assign rx_en_o = ctrl_q.fields.rx_en & ~rx_full;
	assign tx_pop  = tx_en_o & t_done_i;
	assign rx_push = rx_en_o & r_done_i;

	assign baud_div_o = ctrl_q.fields.baud_div;
	assign status     = {rx_empty, rx_full, tx_empty, tx_full}; // 4'b1010 out of reset

	always_ff @(posedge s_axi_aclk_i) begin
		if (!s_axi_aresetn_i) begin
			ctrl_q    <= '0;
			rd_done_o <= 1'b0;
			wr_done_o <= 1'b0;
		end else begin
			rd_done_o <= rd_req_i;
			wr_done_o <= wr_req_i; // misses and full-FIFO writes still complete
			if (ctrl_wr) begin
				for (int i = 0; i < 4; i++) begin
					if (wr_strb_i[i]) begin
						ctrl_q.bytes[i] <= wr_data_i[i*UART_BYTE_W +: UART_BYTE_W];
					end
				end
			end
		end
	end

	// read word, zero on a miss or for write-only wdata
	always_ff @(posedge s_axi_aclk_i) begin
		if (rd_req_i) begin
			rd_data_o <= '0;
			if (rd_hit_i) begin
				case (rd_sel_i)
					REG_CTRL:   rd_data_o <= ctrl_q.bytes;
					REG_STATUS: rd_data_o <= {{(AXI_DATA_W-4){1'b0}}, status};
					REG_RDATA: begin
						if (!rx_empty) begin
							rd_data_o <= {{(AXI_DATA_W-UART_BYTE_W){1'b0}}, rx_head};
						end
					end
					default:    rd_data_o <= '0;
				endcase
			end
		end
	end

	uart_byte_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_tx_fifo (
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.push_i          (tx_push),
		.push_data_i     (wr_data_i[UART_BYTE_W-1:0]),
		.pop_i           (tx_pop),
		.head_o          (tx_o),
		.full_o          (tx_full),
		.empty_o         (tx_empty)
	);

	uart_byte_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_rx_fifo (
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.push_i          (rx_push),
		.push_data_i     (rx_i),
		.pop_i           (rx_pop),
		.head_o          (rx_head),
		.full_o          (rx_full),
		.empty_o         (rx_empty)
	);

endmodule

// File: source/axi_resp_stage.sv
module axi_resp_stage (
	input  logic                                s_axi_aclk_i,
	input  logic                                s_axi_aresetn_i,
	input  logic                                rd_done_i,
	input  logic [uart_axi_pkg::AXI_DATA_W-1:0] rd_data_i,
	input  logic                                wr_done_i,
	input  logic                                s_axi_rready_i,
	input  logic                                s_axi_bready_i,
	output logic                                s_axi_rvalid_o,
	output logic [uart_axi_pkg::AXI_DATA_W-1:0] s_axi_rdata_o,
	output logic                                s_axi_bvalid_o,
	output logic                                rd_busy_o,
	output logic                                wr_busy_o
);

	// busy covers the response being formed and the one waiting on the master
	assign rd_busy_o = rd_done_i | s_axi_rvalid_o;
	assign wr_busy_o = wr_done_i | s_axi_bvalid_o;

	always_ff @(posedge s_axi_aclk_i) begin
		if (!s_axi_aresetn_i) begin
			s_axi_rvalid_o <= 1'b0;
			s_axi_bvalid_o <= 1'b0;
		end else begin
			if (rd_done_i) begin
				s_axi_rvalid_o <= 1'b1;
			end else if (s_axi_rready_i) begin
				s_axi_rvalid_o <= 1'b0; // taken by the master
			end
			if (wr_done_i) begin
				s_axi_bvalid_o <= 1'b1;
			end else if (s_axi_bready_i) begin
				s_axi_bvalid_o <= 1'b0;
			end
		end
	end

	// held stable until rvalid drops
	always_ff @(posedge s_axi_aclk_i) begin
		if (rd_done_i) begin
			s_axi_rdata_o <= rd_data_i;
		end
	end

endmodule

// File: source/axi_uart_top.sv
module axi_uart_top #(
	parameter int FIFO_DEPTH = uart_axi_pkg::FIFO_DEPTH
) (
	input  logic                                  s_axi_aclk_i,
	input  logic                                  s_axi_aresetn_i,
	input  logic [uart_axi_pkg::AXI_ADDR_W-1:0]   s_axi_araddr_i,
	input  logic                                  s_axi_arvalid_i,
	output logic                                  s_axi_arready_o,
	output logic                                  s_axi_rvalid_o,
	output logic [uart_axi_pkg::AXI_DATA_W-1:0]   s_axi_rdata_o,
	input  logic                                  s_axi_rready_i,
	input  logic [uart_axi_pkg::AXI_ADDR_W-1:0]   s_axi_awaddr_i,
	input  logic                                  s_axi_awvalid_i,
	output logic                                  s_axi_awready_o,
	input  logic [uart_axi_pkg::AXI_DATA_W-1:0]   s_axi_wdata_i,
	input  logic [uart_axi_pkg::AXI_DATA_W/8-1:0] s_axi_wstrb_i,
	input  logic                                  s_axi_wvalid_i,
	output logic                                  s_axi_wready_o,
	output logic                                  s_axi_bvalid_o,
	input  logic                                  s_axi_bready_i,
	input  logic [uart_axi_pkg::UART_BYTE_W-1:0]  rx_i,
	input  logic                                  r_done_i,
	input  logic                                  t_done_i,
	output logic [uart_axi_pkg::UART_BYTE_W-1:0]  tx_o,
	output logic                                  tx_en_o,
	output logic                                  rx_en_o,
	output logic [15:0]                           baud_div_o
);
	import uart_axi_pkg::*;

	logic                    rd_req;
	reg_sel_t                rd_sel;
	logic                    rd_hit;
	logic                    wr_req;
	reg_sel_t                wr_sel;
	logic                    wr_hit;
	logic [AXI_DATA_W-1:0]   wr_data;
	logic [AXI_DATA_W/8-1:0] wr_strb;
	logic                    rd_done;
	logic [AXI_DATA_W-1:0]   rd_data;
	logic                    wr_done;
	logic                    rd_busy;
	logic                    wr_busy;

	axi_req_decode u_decode (
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.s_axi_araddr_i  (s_axi_araddr_i),
		.s_axi_arvalid_i (s_axi_arvalid_i),
		.s_axi_awaddr_i  (s_axi_awaddr_i),
		.s_axi_awvalid_i (s_axi_awvalid_i),
		.s_axi_wdata_i   (s_axi_wdata_i),
		.s_axi_wstrb_i   (s_axi_wstrb_i),
		.s_axi_wvalid_i  (s_axi_wvalid_i),
		.rd_busy_i       (rd_busy),
		.wr_busy_i       (wr_busy),
		.s_axi_arready_o (s_axi_arready_o),
		.s_axi_awready_o (s_axi_awready_o),
		.s_axi_wready_o  (s_axi_wready_o),
		.rd_req_o        (rd_req),
		.rd_sel_o        (rd_sel),
		.rd_hit_o        (rd_hit),
		.wr_req_o        (wr_req),
		.wr_sel_o        (wr_sel),
		.wr_hit_o        (wr_hit),
		.wr_data_o       (wr_data),
		.wr_strb_o       (wr_strb)
	);

	uart_reg_stage #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_regs (
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.rd_req_i        (rd_req),
		.rd_sel_i        (rd_sel),
		.rd_hit_i        (rd_hit),
		.wr_req_i        (wr_req),
		.wr_sel_i        (wr_sel),
		.wr_hit_i        (wr_hit),
		.wr_data_i       (wr_data),
		.wr_strb_i       (wr_strb),
		.rx_i            (rx_i),
		.r_done_i        (r_done_i),
		.t_done_i        (t_done_i),
		.rd_done_o       (rd_done),
		.rd_data_o       (rd_data),
		.wr_done_o       (wr_done),
		.tx_o            (tx_o),
		.tx_en_o         (tx_en_o),
		.rx_en_o         (rx_en_o),
		.baud_div_o      (baud_div_o)
	);

	axi_resp_stage u_resp (
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.rd_done_i       (rd_done),
		.rd_data_i       (rd_data),
		.wr_done_i       (wr_done),
		.s_axi_rready_i  (s_axi_rready_i),
		.s_axi_bready_i  (s_axi_bready_i),
		.s_axi_rvalid_o  (s_axi_rvalid_o),
		.s_axi_rdata_o   (s_axi_rdata_o),
		.s_axi_bvalid_o  (s_axi_bvalid_o),
		.rd_busy_o       (rd_busy),
		.wr_busy_o       (wr_busy)
	);

endmodule

// File: bench/axi_uart_properties.sv
module axi_uart_props (
	input logic                                  s_axi_aclk_i,
	input logic                                  s_axi_aresetn_i,
	input logic                                  s_axi_arvalid_i,
	input logic                                  s_axi_arready_o,
	input logic                                  s_axi_rvalid_o,
	input logic [uart_axi_pkg::AXI_DATA_W-1:0]   s_axi_rdata_o,
	input logic                                  s_axi_rready_i,
	input logic [uart_axi_pkg::AXI_ADDR_W-1:0]   s_axi_awaddr_i,
	input logic                                  s_axi_awvalid_i,
	input logic                                  s_axi_awready_o,
	input logic [uart_axi_pkg::AXI_DATA_W-1:0]   s_axi_wdata_i,
	input logic [uart_axi_pkg::AXI_DATA_W/8-1:0] s_axi_wstrb_i,
	input logic                                  s_axi_wvalid_i,
	input logic                                  s_axi_wready_o,
	input logic                                  s_axi_bvalid_o,
	input logic                                  s_axi_bready_i,
	input logic                                  tx_en_o,
	input logic                                  rx_en_o,
	input logic [15:0]                           baud_div_o
);
	import uart_axi_pkg::*;

	int unsigned assert_errs = 0; // read by the testbench at the end
	logic        ar_fire;
	logic        aw_fire;
	logic        baud_wr;

	assign ar_fire = s_axi_arvalid_i & s_axi_arready_o;
	assign aw_fire = s_axi_awvalid_i & s_axi_wvalid_i & s_axi_awready_o & s_axi_wready_o;
	assign baud_wr = aw_fire & (s_axi_awaddr_i == UART_BASE_ADDR) & (s_axi_wstrb_i[3:2] == 2'b11);

	function automatic void flag_failure(input string what);
		$error("%s", what);
		assert_errs++;
	endfunction

	// outputs right after reset release
	a_reset_state: assert property (@(posedge s_axi_aclk_i)
		$rose(s_axi_aresetn_i) |-> s_axi_arready_o && s_axi_awready_o && s_axi_wready_o &&
			!s_axi_rvalid_o && !s_axi_bvalid_o && !tx_en_o && !rx_en_o)
		else flag_failure("outputs not in reset state after reset release");

	// valid is set by the second edge after acceptance
	a_rd_latency: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
		ar_fire |-> ##3 $rose(s_axi_rvalid_o))
		else flag_failure("rvalid not raised two cycles after read acceptance");

	a_wr_latency: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
		aw_fire |-> ##3 $rose(s_axi_bvalid_o))
		else flag_failure("bvalid not raised two cycles after write acceptance");

	a_r_hold: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
		s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o))
		else flag_failure("read response dropped or changed under back-pressure");

	a_b_hold: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
		s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o)
		else flag_failure("write response dropped under back-pressure");

	a_no_ar_pending: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
		s_axi_rvalid_o |-> !s_axi_arready_o)
		else flag_failure("arready high while a read response is pending");

	a_no_aw_pending: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
		s_axi_bvalid_o |-> !s_axi_awready_o)
		else flag_failure("awready high while a write response is pending");

	// baud divisor follows a ctrl write one edge after acceptance
	a_baud_update: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
		baud_wr |-> ##2 baud_div_o == $past(s_axi_wdata_i[31:16], 2))
		else flag_failure("baud_div_o does not match the written ctrl bits 31:16");

endmodule

// File: bench/tb_axi_uart.sv
module tb_axi_uart;
	import uart_axi_pkg::*;

	localparam int DEPTH = 32;
	localparam int TMO   = 200; // cycles allowed per wait
	localparam logic [31:0] A_CTRL   = UART_BASE_ADDR + 32'h0;
	localparam logic [31:0] A_STATUS = UART_BASE_ADDR + 32'h4;
	localparam logic [31:0] A_RDATA  = UART_BASE_ADDR + 32'h8;
	localparam logic [31:0] A_WDATA  = UART_BASE_ADDR + 32'hc;

	logic        clk;
	logic        rstn;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic        rvalid;
	logic [31:0] rdata;
	logic        rready;
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic        bvalid;
	logic        bready;
	logic [7:0]  rx;
	logic        r_done;
	logic        t_done;
	logic [7:0]  tx;
	logic        tx_en;
	logic        rx_en;
	logic [15:0] baud_div;

	string       cur_test;
	int          test_errs;
	int          err_cnt;
	int          test_cnt;
	bit          stall_en;
	logic [31:0] ctrl_model; // expected ctrl contents
	logic [31:0] rd_val;
	logic [31:0] wr_val;
	logic [7:0]  b_val;
	logic [7:0]  byte_q [$];

	bind axi_uart_top axi_uart_props u_props (.*);

	axi_uart_top #(
		.FIFO_DEPTH (DEPTH)
	) u_axi_uart_top (
		.s_axi_aclk_i    (clk),
		.s_axi_aresetn_i (rstn),
		.s_axi_araddr_i  (araddr),
		.s_axi_arvalid_i (arvalid),
		.s_axi_arready_o (arready),
		.s_axi_rvalid_o  (rvalid),
		.s_axi_rdata_o   (rdata),
		.s_axi_rready_i  (rready),
		.s_axi_awaddr_i  (awaddr),
		.s_axi_awvalid_i (awvalid),
		.s_axi_awready_o (awready),
		.s_axi_wdata_i   (wdata),
		.s_axi_wstrb_i   (wstrb),
		.s_axi_wvalid_i  (wvalid),
		.s_axi_wready_o  (wready),
		.s_axi_bvalid_o  (bvalid),
		.s_axi_bready_i  (bready),
		.rx_i            (rx),
		.r_done_i        (r_done),
		.t_done_i        (t_done),
		.tx_o            (tx),
		.tx_en_o         (tx_en),
		.rx_en_o         (rx_en),
		.baud_div_o      (baud_div)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_on_timeout(input string what);
		$display("timeout: no %s within %0d cycles in test %s", what, TMO, cur_test);
		$display("Test failed");
		$finish;
	endtask

	task automatic check_eq(input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("Fail %s expected 0x%08h actual 0x%08h", cur_test, exp, act);
			test_errs++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		$display("test %-12s done, %0d errors", cur_test, test_errs);
		err_cnt += test_errs;
		test_cnt++;
	endtask

	// called right after a rising edge
	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
		int n;
		bit ok;
		araddr  <= addr;
		arvalid <= 1'b1;
		n  = 0;
		ok = 1'b0;
		while (!ok && n < TMO) begin
			@(posedge clk);
			ok = arready;
			n++;
		end
		arvalid <= 1'b0;
		if (!ok) begin
			abort_on_timeout("read address handshake");
		end
		n  = 0;
		ok = 1'b0;
		while (!ok && n < TMO) begin
			rready <= stall_en ? 1'($urandom_range(1, 0)) : 1'b1; // random stalls
			@(posedge clk);
			ok   = rvalid & rready;
			data = rdata;
			n++;
		end
		rready <= 1'b0;
		if (!ok) begin
			abort_on_timeout("read response");
		end
	endtask

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int n;
		bit ok;
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wstrb   <= strb;
		wvalid  <= 1'b1;
		n  = 0;
		ok = 1'b0;
		while (!ok && n < TMO) begin
			@(posedge clk);
			ok = awready & wready;
			n++;
		end
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		if (!ok) begin
			abort_on_timeout("write address handshake");
		end
		n  = 0;
		ok = 1'b0;
		while (!ok && n < TMO) begin
			bready <= stall_en ? 1'($urandom_range(1, 0)) : 1'b1;
			@(posedge clk);
			ok = bvalid & bready;
			n++;
		end
		bready <= 1'b0;
		if (!ok) begin
			abort_on_timeout("write response");
		end
	endtask

	initial begin
		void'($urandom(32'hd86e));
		rstn    = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		rx      = '0;
		r_done  = 1'b0;
		t_done  = 1'b0;
		stall_en   = 1'b0;
		err_cnt    = 0;
		test_cnt   = 0;
		ctrl_model = '0;
		repeat (5) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);

		start_test("reset_values");
		axi_read(A_STATUS, rd_val);
		check_eq(32'h0000_000a, rd_val);
		axi_read(A_CTRL, rd_val);
		check_eq(32'h0, rd_val);
		axi_write(A_WDATA, 32'h0, 4'b0000); // no strobe means nothing is pushed
		end_test();

		start_test("stalls");
		stall_en = 1'b1;
		for (int i = 0; i < 8; i++) begin
			wr_val = $urandom;
			axi_write(A_CTRL, wr_val, 4'b1100);
			ctrl_model[31:16] = wr_val[31:16];
			axi_read(A_CTRL, rd_val);
			check_eq(ctrl_model, rd_val);
		end
		end_test();

		start_test("ctrl_strobe");
		axi_write(A_CTRL, 32'h5a5a_00f0, 4'b1111);
		ctrl_model = 32'h5a5a_00f0;
		axi_write(A_CTRL, 32'hbeef_ffff, 4'b1100); // upper half only
		ctrl_model = {16'hbeef, ctrl_model[15:0]};
		check_eq(32'h0000_beef, {16'h0, baud_div});
		axi_read(A_CTRL, rd_val);
		check_eq(ctrl_model, rd_val);
		end_test();

		start_test("tx_drain");
		axi_write(A_CTRL, 32'h0000_0001, 4'b0001);
		ctrl_model[7:0] = 8'h01;
		check_eq(32'h0, {31'h0, tx_en}); // enabled but queue empty
		for (int i = 0; i < 4; i++) begin
			b_val = 8'($urandom);
			byte_q.push_back(b_val);
			axi_write(A_WDATA, {24'h0, b_val}, 4'b0001);
		end
		while (byte_q.size() > 0) begin
			check_eq(32'h1, {31'h0, tx_en});
			check_eq({24'h0, byte_q.pop_front()}, {24'h0, tx});
			t_done <= 1'b1;
			@(posedge clk);
			t_done <= 1'b0;
			@(posedge clk);
		end
		check_eq(32'h0, {31'h0, tx_en});
		axi_read(A_STATUS, rd_val);
		check_eq(32'h0000_000a, rd_val);
		end_test();

		start_test("rx_fill");
		axi_write(A_CTRL, 32'h0000_0002, 4'b0001);
		ctrl_model[7:0] = 8'h02;
		for (int i = 0; i < DEPTH; i++) begin
			b_val = 8'($urandom);
			byte_q.push_back(b_val);
			rx     <= b_val;
			r_done <= 1'b1;
			@(posedge clk);
		end
		r_done <= 1'b0;
		@(posedge clk);
		check_eq(32'h0, {31'h0, rx_en}); // receive held off once full
		axi_read(A_STATUS, rd_val);
		check_eq(32'h0000_0006, rd_val);
		while (byte_q.size() > 0) begin
			axi_read(A_RDATA, rd_val);
			check_eq({24'h0, byte_q.pop_front()}, rd_val);
		end
		axi_read(A_RDATA, rd_val);
		check_eq(32'h0, rd_val);
		end_test();

		start_test("out_of_window");
		axi_read(32'h3000_0000, rd_val);
		check_eq(32'h0, rd_val);
		axi_write(UART_BASE_ADDR + 32'h10, 32'hffff_ffff, 4'b1111);
		axi_read(A_CTRL, rd_val);
		check_eq(ctrl_model, rd_val);
		end_test();

		$display("%0d tests, %0d value mismatches, %0d assertion failures", test_cnt, err_cnt,
			u_axi_uart_top.u_props.assert_errs);
		if (err_cnt == 0 && u_axi_uart_top.u_props.assert_errs == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: flist.f
source/uart_axi_pkg.sv
source/axi_req_decode.sv
source/uart_byte_fifo.sv
source/uart_reg_stage.sv
source/axi_resp_stage.sv
source/axi_uart_top.sv
bench/axi_uart_properties.sv
bench/tb_axi_uart.sv

// File: Bender.yml
package:
  name: axi_uart

sources:
  - source/uart_axi_pkg.sv
  - source/axi_req_decode.sv
  - source/uart_byte_fifo.sv
  - source/uart_reg_stage.sv
  - source/axi_resp_stage.sv
  - source/axi_uart_top.sv
  - target: test
    files:
      - bench/axi_uart_properties.sv
      - bench/tb_axi_uart.sv
